//--- excPkg.sv
`default_nettype none

package excPkg;

    // exception flags gathered along the pipeline, in pipeline order
    typedef struct packed {
        logic interrupt;
        logic wrongAddrIf;
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic eret;
        logic wrWrongAddrMem;
        logic rdWrongAddrMem;
        logic overflow;
        logic tlbRefill;
        logic tlbInvalid;
        logic tlbModified;
        // qualifies tlbRefill or tlbInvalid, not a cause on its own
        logic tlbStore;
        logic refetch;
        logic trap;
    } excFlagsT;

    typedef struct packed {
        logic regWe;
        logic hiWe;
        logic loWe;
    } regsWrT;

    typedef struct packed {
        logic id;
        logic exe;
        logic mem;
    } flushT;

    typedef enum logic [1:0] {
        kindNone      = 2'b00,
        kindException = 2'b01,
        kindEret      = 2'b10,
        kindRefetch   = 2'b11
    } redirectKindT;

    typedef struct packed {
        redirectKindT kind;
        logic [31:0]  target;
    } redirectT;

    // move-to-CP0 from the pipeline
    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0WriteT;

    typedef enum logic {
        badFromPc  = 1'b0,
        badFromMem = 1'b1
    } badAddrSelT;

    localparam logic [4:0] cp0BadVAddr = 5'd8;
    localparam logic [4:0] cp0Status   = 5'd12;
    localparam logic [4:0] cp0Cause    = 5'd13;
    localparam logic [4:0] cp0Epc      = 5'd14;

    localparam logic [4:0] excInt  = 5'd0;
    localparam logic [4:0] excMod  = 5'd1;
    localparam logic [4:0] excTlbl = 5'd2;
    localparam logic [4:0] excTlbs = 5'd3;
    localparam logic [4:0] excAdel = 5'd4;
    localparam logic [4:0] excAdes = 5'd5;
    localparam logic [4:0] excSys  = 5'd8;
    localparam logic [4:0] excBp   = 5'd9;
    localparam logic [4:0] excRi   = 5'd10;
    localparam logic [4:0] excOv   = 5'd12;
    localparam logic [4:0] excTr   = 5'd13;

    // single vector for every exception, no BEV handling
    localparam logic [31:0] excVector = 32'hBFC00380;

endpackage

`default_nettype wire

//--- exceptionDetect.sv
`timescale 1ns/100ps
`default_nettype none

module exceptionDetect import excPkg::*; (
    input  wire regsWrT       memRegsWr,
    input  wire excFlagsT     memExc,
    input  wire [31:0]        memPc,
    input  wire [7:0]         imMask,
    input  wire               exl,
    input  wire               ie,
    input  wire [7:0]         ipPending,
    output regsWrT            regsWrFinal,
    output flushT             flush,
    output redirectKindT      kind,
    output excFlagsT          excFinal
);

    excFlagsT causeOnly;
    logic     anyExc;

    // interrupt and fetch alignment are decided here, the rest arrive from earlier stages
    always_comb begin
        excFinal             = memExc;
        excFinal.interrupt   = ((ipPending & imMask) != 8'b0) && !exl && ie;
        excFinal.wrongAddrIf = (memPc[1:0] != 2'b00);
    end

    always_comb begin
        causeOnly          = excFinal;
        causeOnly.tlbStore = 1'b0;
    end

    assign anyExc = (causeOnly != '0);

    always_comb begin
        if (anyExc) begin
            if (excFinal.refetch) begin
                kind = kindRefetch;
            end else if (excFinal.eret) begin
                kind = kindEret;
            end else begin
                kind = kindException;
            end
            flush       = '{id: 1'b1, exe: 1'b1, mem: 1'b1};
            // the faulting instruction must not retire
            regsWrFinal = '0;
        end else begin
            kind        = kindNone;
            flush       = '0;
            regsWrFinal = memRegsWr;
        end
    end

endmodule

`default_nettype wire

//--- excCodeEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module excCodeEncoder import excPkg::*; (
    input  wire excFlagsT excFinal,
    output logic [4:0]    excCode,
    output badAddrSelT    badSel
);

    // highest priority first; fetch-side TLB faults are not modelled
    always_comb begin
        badSel = badFromMem;
        if (excFinal.interrupt) begin
            excCode = excInt;
        end else if (excFinal.wrongAddrIf) begin
            excCode = excAdel;
            badSel  = badFromPc;
        end else if (excFinal.reservedInstr) begin
            excCode = excRi;
        end else if (excFinal.overflow) begin
            excCode = excOv;
        end else if (excFinal.trap) begin
            excCode = excTr;
        end else if (excFinal.syscall) begin
            excCode = excSys;
        end else if (excFinal.brk) begin
            excCode = excBp;
        end else if (excFinal.rdWrongAddrMem) begin
            excCode = excAdel;
        end else if (excFinal.wrWrongAddrMem) begin
            excCode = excAdes;
        end else if (excFinal.tlbRefill || excFinal.tlbInvalid) begin
            // refill and invalid share a code, split by access direction
            excCode = excFinal.tlbStore ? excTlbs : excTlbl;
        end else if (excFinal.tlbModified) begin
            excCode = excMod;
        end else begin
            // don't care, only sampled on kindException
            excCode = excInt;
            badSel  = badFromPc;
        end
    end

endmodule

`default_nettype wire

//--- cp0Regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Regs import excPkg::*; (
    input  wire               clk,
    input  wire               arstN,
    input  wire redirectKindT kind,
    input  wire [4:0]         excCode,
    input  wire badAddrSelT   badSel,
    input  wire [31:0]        memPc,
    input  wire [31:0]        memBadAddr,
    input  wire [5:0]         hwInt,
    input  wire cp0WriteT     cp0Wr,
    input  wire [4:0]         cp0RdAddr,
    output logic [31:0]       cp0RdData,
    output logic [7:0]        imMask,
    output logic              exl,
    output logic              ie,
    output logic [7:0]        ipPending,
    output logic [31:0]       epc
);

    logic [31:0] badVAddr;
    logic [4:0]  causeExcCode;
    logic [1:0]  causeSwIp;
    logic        excTaken;
    logic        eretTaken;
    logic        mtc0;
    logic        badAddrCode;

    assign excTaken  = (kind == kindException);
    assign eretTaken = (kind == kindEret);
    // a flushed slot (exception, eret, refetch) never commits its mtc0
    assign mtc0      = cp0Wr.we && (kind == kindNone);

    assign badAddrCode = excCode inside {excAdel, excAdes, excTlbl, excTlbs, excMod};

    // hardware lines are not latched
    assign ipPending = {hwInt, causeSwIp};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            imMask <= '0;
            exl    <= 1'b0;
            ie     <= 1'b0;
        end else if (excTaken) begin
            exl <= 1'b1;
        end else if (eretTaken) begin
            exl <= 1'b0;
        end else if (mtc0 && cp0Wr.addr == cp0Status) begin
            imMask <= cp0Wr.data[15:8];
            exl    <= cp0Wr.data[1];
            ie     <= cp0Wr.data[0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            causeExcCode <= '0;
            causeSwIp    <= '0;
        end else if (excTaken) begin
            causeExcCode <= excCode;
        end else if (mtc0 && cp0Wr.addr == cp0Cause) begin
            causeSwIp <= cp0Wr.data[9:8];
        end
    end

    // nested exception keeps the first return address
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epc <= '0;
        end else if (excTaken) begin
            if (!exl) begin
                epc <= memPc;
            end
        end else if (mtc0 && cp0Wr.addr == cp0Epc) begin
            epc <= cp0Wr.data;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            badVAddr <= '0;
        end else if (excTaken && badAddrCode) begin
            badVAddr <= (badSel == badFromPc) ? memPc : memBadAddr;
        end
    end

    always_comb begin
        case (cp0RdAddr)
            cp0BadVAddr: cp0RdData = badVAddr;
            cp0Status:   cp0RdData = {16'b0, imMask, 6'b0, exl, ie};
            cp0Cause:    cp0RdData = {16'b0, hwInt, causeSwIp, 1'b0, causeExcCode, 2'b0};
            cp0Epc:      cp0RdData = epc;
            default:     cp0RdData = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- pcRedirect.sv
`timescale 1ns/100ps
`default_nettype none

module pcRedirect import excPkg::*; (
    input  wire redirectKindT kind,
    input  wire [31:0]        epc,
    input  wire [31:0]        memPc,
    output redirectT          redirect
);

    always_comb begin
        redirect.kind = kind;
        case (kind)
            kindException: begin
                redirect.target = excVector;
            end
            kindEret: begin
                redirect.target = epc;
            end
            kindRefetch: begin
                // replay the instruction sitting in the memory stage
                redirect.target = memPc;
            end
            default: begin
                redirect.target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- exceptionUnit.sv
`timescale 1ns/100ps
`default_nettype none

module exceptionUnit import excPkg::*; (
    input  wire           clk,
    input  wire           arstN,
    input  wire regsWrT   memRegsWr,
    input  wire excFlagsT memExc,
    input  wire [31:0]    memPc,
    input  wire [31:0]    memBadAddr,
    input  wire [5:0]     hwInt,
    input  wire cp0WriteT cp0Wr,
    input  wire [4:0]     cp0RdAddr,
    output regsWrT        regsWrFinal,
    output flushT         flush,
    output redirectT      redirect,
    output excFlagsT      excFinal,
    output logic [31:0]   cp0RdData
);

    logic [7:0]   imMask;
    logic         exl;
    logic         ie;
    logic [7:0]   ipPending;
    logic [31:0]  epc;
    redirectKindT kind;
    logic [4:0]   excCode;
    badAddrSelT   badSel;

    exceptionDetect u_detect (
        .memRegsWr   (memRegsWr),
        .memExc      (memExc),
        .memPc       (memPc),
        .imMask      (imMask),
        .exl         (exl),
        .ie          (ie),
        .ipPending   (ipPending),
        .regsWrFinal (regsWrFinal),
        .flush       (flush),
        .kind        (kind),
        .excFinal    (excFinal)
    );

    excCodeEncoder u_encoder (
        .excFinal (excFinal),
        .excCode  (excCode),
        .badSel   (badSel)
    );

    cp0Regs u_cp0 (
        .clk        (clk),
        .arstN      (arstN),
        .kind       (kind),
        .excCode    (excCode),
        .badSel     (badSel),
        .memPc      (memPc),
        .memBadAddr (memBadAddr),
        .hwInt      (hwInt),
        .cp0Wr      (cp0Wr),
        .cp0RdAddr  (cp0RdAddr),
        .cp0RdData  (cp0RdData),
        .imMask     (imMask),
        .exl        (exl),
        .ie         (ie),
        .ipPending  (ipPending),
        .epc        (epc)
    );

    pcRedirect u_redirect (
        .kind     (kind),
        .epc      (epc),
        .memPc    (memPc),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic arstN
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // reset held low over the first two rising edges
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- exceptionUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module exceptionUnitTb import excPkg::*; ();

    logic         clk;
    logic         arstN;
    regsWrT       memRegsWr;
    excFlagsT     memExc;
    logic [31:0]  memPc;
    logic [31:0]  memBadAddr;
    logic [5:0]   hwInt;
    cp0WriteT     cp0Wr;
    logic [4:0]   cp0RdAddr;
    regsWrT       regsWrFinal;
    flushT        flush;
    redirectT     redirect;
    excFlagsT     excFinal;
    logic [31:0]  cp0RdData;

    // one row per case, 9 driven columns followed by 6 expected columns
    logic [127:0] names [0:63];
    logic [31:0]  rows [0:63][0:14];
    int           caseCount = 0;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    logic         loadOk;

    tbClockGen u_clk (
        .clk   (clk),
        .arstN (arstN)
    );

    exceptionUnit u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .memRegsWr   (memRegsWr),
        .memExc      (memExc),
        .memPc       (memPc),
        .memBadAddr  (memBadAddr),
        .hwInt       (hwInt),
        .cp0Wr       (cp0Wr),
        .cp0RdAddr   (cp0RdAddr),
        .regsWrFinal (regsWrFinal),
        .flush       (flush),
        .redirect    (redirect),
        .excFinal    (excFinal),
        .cp0RdData   (cp0RdData)
    );

    task automatic checkValue(input logic [127:0] name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %0s %0s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    task automatic loadCases;
        int           fd;
        int           got;
        string        line;
        logic [127:0] nm;
        logic [31:0]  v [0:14];
        loadOk = 1'b0;
        fd = $fopen("exceptionCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file exceptionCases.txt");
            errors++;
            return;
        end
        loadOk = 1'b1;
        while (loadOk && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                          v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (got != 16 || caseCount == 64) begin
                $display("the cases file has a malformed or surplus line: %0s", line);
                errors++;
                loadOk = 1'b0;
            end else begin
                names[caseCount] = nm;
                for (int k = 0; k < 15; k++) begin
                    rows[caseCount][k] = v[k];
                end
                caseCount++;
            end
        end
        $fclose(fd);
        if (loadOk && caseCount == 0) begin
            $display("the cases file holds no cases");
            errors++;
            loadOk = 1'b0;
        end
    endtask

    task automatic checkStep(input int i);
        checkValue(names[i], "flush", rows[i][9], 32'(flush));
        checkValue(names[i], "kind", rows[i][10], 32'(redirect.kind));
        checkValue(names[i], "target", rows[i][11], redirect.target);
        checkValue(names[i], "regsWrFinal", rows[i][12], 32'(regsWrFinal));
        checkValue(names[i], "excFinal", rows[i][13], 32'(excFinal));
        checkValue(names[i], "cp0RdData", rows[i][14], cp0RdData);
    endtask

    initial begin
        memRegsWr  <= '0;
        memExc     <= '0;
        memPc      <= '0;
        memBadAddr <= '0;
        hwInt      <= '0;
        cp0Wr      <= '0;
        cp0RdAddr  <= '0;
        loadCases();
        if (loadOk) begin
            @(posedge arstN);
            for (int i = 0; i < caseCount; i++) begin
                @(posedge clk);
                memExc     <= rows[i][0][14:0];
                memRegsWr  <= rows[i][1][2:0];
                memPc      <= rows[i][2];
                memBadAddr <= rows[i][3];
                hwInt      <= rows[i][4][5:0];
                cp0Wr      <= '{we: rows[i][5][0], addr: rows[i][6][4:0], data: rows[i][7]};
                cp0RdAddr  <= rows[i][8][4:0];
                // outputs settle well before the falling edge
                @(negedge clk);
                checkStep(i);
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > caseCount + 20) begin
            $display("timeout, the cases did not finish within %0d cycles", caseCount + 20);
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- exceptionCases.txt
# name memExc regsWr memPc memBadAddr hwInt we addr data rdAddr, then expected
# flush kind target regsWrFinal excFinal cp0RdData, all values in hex
pass     0000 7 00400000 00000000 00 0 00 00000000 09 0 0 00000000 7 0000 00000000
sys      0800 4 00400004 00000000 00 0 00 00000000 0d 7 1 bfc00380 0 0800 00000000
rdCause  0000 0 00400008 00000000 00 0 00 00000000 0d 0 0 00000000 0 0000 00000020
eret     0200 0 00400100 00000000 00 0 00 00000000 0c 7 2 00400004 0 0200 00000002
ov       0040 1 00400200 00000000 00 0 00 00000000 0c 7 1 bfc00380 0 0040 00000000
nested   0800 0 00400300 00000000 00 0 00 00000000 0d 7 1 bfc00380 0 0800 00000030
rdEpc    0000 2 00400304 00000000 00 0 00 00000000 0e 0 0 00000000 2 0000 00400200
clrExl   0000 0 00400308 00000000 00 1 0c 00000000 0d 0 0 00000000 0 0000 00000020
misPc    0000 4 00400402 00000000 00 0 00 00000000 08 7 1 bfc00380 0 2000 00000000
rdBadPc  0000 0 00400404 00000000 00 0 00 00000000 08 0 0 00000000 0 0000 00400402
clrExl2  0000 0 00400408 00000000 00 1 0c 00000000 0e 0 0 00000000 0 0000 00400402
stFault  0100 4 00400500 10000003 00 0 00 00000000 0d 7 1 bfc00380 0 0100 00000010
prio     0840 0 00400600 00000000 00 0 00 00000000 08 7 1 bfc00380 0 0840 10000003
setIm    0000 0 00400604 00000000 00 1 0c 00008401 0d 0 0 00000000 0 0000 00000030
intOn    0000 4 00400700 00000000 20 0 00 00000000 0c 7 1 bfc00380 0 4000 00008401
intExl   0000 7 00400704 00000000 20 0 00 00000000 0d 0 0 00000000 7 0000 00008000
ieOff    0000 0 00400708 00000000 20 1 0c 00008400 0e 0 0 00000000 0 0000 00400700
intIeOff 0000 0 0040070c 00000000 20 1 0c 00000201 0c 0 0 00000000 0 0000 00008400
maskOff  0000 3 00400710 00000000 20 1 0d 00000200 0c 0 0 00000000 3 0000 00000201
swInt    0000 0 00400800 00000000 00 0 00 00000000 0d 7 1 bfc00380 0 4000 00000200
refetch  0802 0 00400900 00000000 00 0 00 00000000 0e 7 3 00400900 0 0802 00400800
precWr   0040 0 00400a00 00000000 00 1 0e 12345678 0e 7 1 bfc00380 0 0040 00400800
wrBad    0000 0 00400a04 00000000 00 1 08 ffffffff 0e 0 0 00000000 0 0000 00400800
rdBad    0000 0 00400a08 00000000 00 0 00 00000000 08 0 0 00000000 0 0000 10000003

//--- project.f
excPkg.sv
exceptionDetect.sv
excCodeEncoder.sv
cp0Regs.sv
pcRedirect.sv
exceptionUnit.sv
tbClockGen.sv
exceptionUnitTb.sv

//--- Makefile
TOP       ?= exceptionUnitTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
